// ==== src/hist_pkg.sv ====
/*
  Shared widths and enums for the streaming histogram unit
  Bin index is the upper bin_width bits of a sample
  Counters saturate at count_max and never wrap
*/
package hist_pkg;

  // Sample and bin geometry
  localparam int sample_width = 12;
  localparam int bin_count = 64;
  localparam int bin_width = 6;

  // Per-bin counter
  localparam int count_width = 16;
  localparam logic [count_width-1:0] count_max = {count_width{1'b1}};

  // Host command opcodes
  typedef enum logic {
    op_clear = 1'b0,
    op_read  = 1'b1
  } hist_op_e;

  // Command controller states
  typedef enum logic [2:0] {
    st_run     = 3'd0,
    st_drain   = 3'd1,
    st_clear   = 3'd2,
    st_read    = 3'd3,
    st_respond = 3'd4
  } ctrl_state_e;

endpackage

// ==== src/hist_if.sv ====
/*
  Internal links of the histogram unit
  bin_stream_if transfers on valid and ready both high
  host_access_if req only while busy is low and intake is held
*/
`timescale 1ns/1ps

interface bin_stream_if;
  import hist_pkg::*;

  logic valid;
  logic ready;
  logic [bin_width-1:0] bin;
  // Intake stop from the controller
  logic hold;

  modport src (output valid, output bin, input ready, input hold);
  modport dst (input valid, input bin, output ready);
  modport ctl (output hold);
endinterface

interface host_access_if;
  import hist_pkg::*;

  logic req;
  // High for a clear write, low for a bin read
  logic write;
  logic [bin_width-1:0] bin;
  // Valid the cycle after a read req
  logic [count_width-1:0] read_count;
  logic busy;

  modport ctl (output req, output write, output bin, input read_count, input busy);
  modport acc (input req, input write, input bin, output read_count, output busy);
endinterface

// ==== src/true_dual_port_ram.sv ====
/*
  Two synchronous read-write ports, each on its own clock
  Reads are registered and return the old word on any collision
  Contents are undefined after power-up; no reset
*/
`timescale 1ns/1ps

module true_dual_port_ram #(
  parameter int width = 8,
  parameter int depth = 16
) (
  // Port 0
  input  logic                     port_0_clock,
  input  logic                     port_0_write_enable,
  input  logic                     port_0_read_enable,
  input  logic [$clog2(depth)-1:0] port_0_address,
  input  logic [width-1:0]         port_0_write_data,
  output logic [width-1:0]         port_0_read_data,
  // Port 1
  input  logic                     port_1_clock,
  input  logic                     port_1_write_enable,
  input  logic                     port_1_read_enable,
  input  logic [$clog2(depth)-1:0] port_1_address,
  input  logic [width-1:0]         port_1_write_data,
  output logic [width-1:0]         port_1_read_data
);

  logic [width-1:0] memory [depth];

  // Port 0 write and registered read
  always @(posedge port_0_clock) begin
    if (port_0_write_enable) begin
      memory[port_0_address] <= port_0_write_data;
    end
    if (port_0_read_enable) begin
      port_0_read_data <= memory[port_0_address];
    end
  end

  // Port 1 write and registered read
  always @(posedge port_1_clock) begin
    if (port_1_write_enable) begin
      memory[port_1_address] <= port_1_write_data;
    end
    if (port_1_read_enable) begin
      port_1_read_data <= memory[port_1_address];
    end
  end

  // Sampled on port 0 clock, only meaningful when both ports share it
  a_no_double_write : assert property (@(posedge port_0_clock)
    !(port_0_write_enable && port_1_write_enable && port_0_address == port_1_address));

endmodule

// ==== src/bin_classifier.sv ====
/*
  One-entry input register mapping a sample to its bin
  Bin is the upper bin_width bits; lower bits are discarded
  Intake closes under hold, a held entry still drains
*/
`timescale 1ns/1ps

module bin_classifier (
  input  logic                              port_0_clock,
  input  logic                              rst,
  input  logic                              in_valid,
  input  logic [hist_pkg::sample_width-1:0] in_sample,
  output logic                              in_ready,
  bin_stream_if.src                         out
);
  import hist_pkg::*;

  // Intake enable, low through reset
  logic open_q;
  // Entry occupied
  logic full_q;
  logic [bin_width-1:0] bin_q;
  logic take;
  logic drain;

  // Entry leaves this cycle
  assign drain = full_q && out.ready;

  // Room when empty or emptying, never under hold
  assign in_ready = open_q && !out.hold && (!full_q || out.ready);
  assign take = in_valid && in_ready;

  always_ff @(posedge port_0_clock) begin
    if (rst) begin
      open_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      open_q <= 1'b1;
      if (take) begin
        full_q <= 1'b1;
      end else if (drain) begin
        full_q <= 1'b0;
      end
    end
  end

  // Bin extraction
  always_ff @(posedge port_0_clock) begin
    if (take) begin
      bin_q <= in_sample[sample_width-1 -: bin_width];
    end
  end

  // Pending flag doubles as stream valid
  assign out.valid = full_q;
  assign out.bin = bin_q;

  // A stalled entry stays put until taken
  a_valid_holds : assert property (@(posedge port_0_clock) disable iff (rst)
    out.valid && !out.ready |=> out.valid && $stable(out.bin));

endmodule

// ==== src/bin_accumulator.sv ====
/*
  Two-stage read-modify-write of bin counters
  Stage one reads on RAM port 0, stage two writes on port 1
  Back-to-back same-bin updates use the forwarded count
  Host access assumes an empty pipeline
*/
`timescale 1ns/1ps

module bin_accumulator (
  input  logic         port_0_clock,
  input  logic         rst,
  bin_stream_if.dst    in,
  host_access_if.acc   host
);
  import hist_pkg::*;

  logic accept;

  // Stage one, read issued
  logic s1_valid;
  logic [bin_width-1:0] s1_bin;

  // Stage two, read data back, write issued
  logic s2_valid;
  logic [bin_width-1:0] s2_bin;
  logic [count_width-1:0] s2_old;
  logic [count_width-1:0] s2_new;

  // Forwarded count for a same-bin follower
  logic fwd_q;
  logic [count_width-1:0] fwd_count;

  // Host access decode
  logic host_rd;
  logic host_wr;

  // RAM port signals
  logic rd_en;
  logic [bin_width-1:0] rd_addr;
  logic [count_width-1:0] rd_data;
  logic wr_en;
  logic [bin_width-1:0] wr_addr;
  logic [count_width-1:0] wr_data;

  assign host_rd = host.req && !host.write;
  assign host_wr = host.req && host.write;

  // Intake stalls only for the host
  assign in.ready = !host.req;
  assign accept = in.valid && in.ready;

  always_ff @(posedge port_0_clock) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      fwd_q <= 1'b0;
    end else begin
      s1_valid <= accept;
      s2_valid <= s1_valid;
      // RAM misses the write landing on this same edge
      fwd_q <= s1_valid && s2_valid && (s1_bin == s2_bin);
    end
  end

  always_ff @(posedge port_0_clock) begin
    if (accept) begin
      s1_bin <= in.bin;
    end
    s2_bin <= s1_bin;
    fwd_count <= s2_new;
  end

  // Old count and saturating increment
  assign s2_old = fwd_q ? fwd_count : rd_data;
  assign s2_new = (s2_old == count_max) ? count_max : s2_old + 1'b1;

  // Port 0 read, pipeline or host
  assign rd_en = s1_valid || host_rd;
  assign rd_addr = host_rd ? host.bin : s1_bin;

  // Port 1 write, pipeline or clear
  assign wr_en = s2_valid || host_wr;
  assign wr_addr = host_wr ? host.bin : s2_bin;
  assign wr_data = host_wr ? {count_width{1'b0}} : s2_new;

  true_dual_port_ram #(
    .width(count_width),
    .depth(bin_count)
  ) ram (
    .port_0_clock(port_0_clock),
    .port_0_write_enable(1'b0),
    .port_0_read_enable(rd_en),
    .port_0_address(rd_addr),
    .port_0_write_data({count_width{1'b0}}),
    .port_0_read_data(rd_data),
    .port_1_clock(port_0_clock),
    .port_1_write_enable(wr_en),
    .port_1_read_enable(1'b0),
    .port_1_address(wr_addr),
    .port_1_write_data(wr_data),
    .port_1_read_data()
  );

  // Host read result lands one cycle after req
  assign host.read_count = rd_data;

  // Pending classifier entry counts as in flight
  assign host.busy = in.valid || s1_valid || s2_valid;

  // Controller must wait out the drain before any access
  a_req_idle : assert property (@(posedge port_0_clock) disable iff (rst)
    host.req |-> !(in.valid || s1_valid || s2_valid));

endmodule

// ==== src/histogram_control.sv ====
/*
  Host command FSM: latch, hold intake, drain, then clear or read
  One command at a time; rsp_valid is a single-cycle pulse
  Clear sweeps all bins with one write per cycle, rsp_count zero
*/
`timescale 1ns/1ps

module histogram_control (
  input  logic                             port_0_clock,
  input  logic                             rst,
  input  logic                             cmd_valid,
  input  hist_pkg::hist_op_e               cmd_op,
  input  logic [hist_pkg::bin_width-1:0]   cmd_bin,
  output logic                             cmd_ready,
  output logic                             rsp_valid,
  output logic [hist_pkg::count_width-1:0] rsp_count,
  bin_stream_if.ctl                        stream,
  host_access_if.ctl                       host
);
  import hist_pkg::*;

  ctrl_state_e state;

  // Latched command
  hist_op_e op_q;
  logic [bin_width-1:0] bin_q;

  // Clear sweep position
  logic [bin_width-1:0] sweep_bin;
  logic sweep_last;
  logic cmd_take;

  assign cmd_take = cmd_valid && cmd_ready;
  assign sweep_last = (sweep_bin == bin_width'(bin_count - 1));

  always_ff @(posedge port_0_clock) begin
    if (rst) begin
      state <= st_run;
      cmd_ready <= 1'b0;
      sweep_bin <= '0;
    end else begin
      case (state)
        st_run: begin
          if (cmd_take) begin
            cmd_ready <= 1'b0;
            state <= st_drain;
          end else begin
            cmd_ready <= 1'b1;
          end
        end
        st_drain: begin
          // Busy seen low with hold already up
          if (!host.busy) begin
            sweep_bin <= '0;
            state <= (op_q == op_clear) ? st_clear : st_read;
          end
        end
        st_clear: begin
          sweep_bin <= sweep_bin + 1'b1;
          if (sweep_last) begin
            state <= st_respond;
          end
        end
        st_read: begin
          state <= st_respond;
        end
        st_respond: begin
          state <= st_run;
          cmd_ready <= 1'b1;
        end
        default: begin
          state <= st_run;
        end
      endcase
    end
  end

  // Command payload
  always_ff @(posedge port_0_clock) begin
    if (cmd_take) begin
      op_q <= cmd_op;
      bin_q <= cmd_bin;
    end
  end

  // Intake closed for the whole command
  assign stream.hold = (state != st_run);

  assign host.req = (state == st_clear) || (state == st_read);
  assign host.write = (state == st_clear);
  assign host.bin = (state == st_clear) ? sweep_bin : bin_q;

  // Read data arrives during st_respond
  assign rsp_valid = (state == st_respond);
  assign rsp_count = (op_q == op_read) ? host.read_count : {count_width{1'b0}};

  // Single pulse, and intake reopens right after
  a_rsp_pulse : assert property (@(posedge port_0_clock) disable iff (rst)
    rsp_valid |=> !rsp_valid && !stream.hold);

endmodule

// ==== src/histogram_top.sv ====
/*
  Streaming histogram, single clock port_0_clock
  Samples stall while a host command runs
  Issue a clear before the first read, RAM starts undefined
*/
`timescale 1ns/1ps

module histogram_top (
  input  logic                             port_0_clock,
  input  logic                             rst,
  // Sample stream
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [hist_pkg::sample_width-1:0] in_sample,
  // Host commands
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  hist_pkg::hist_op_e               cmd_op,
  input  logic [hist_pkg::bin_width-1:0]   cmd_bin,
  // Response pulse
  output logic                             rsp_valid,
  output logic [hist_pkg::count_width-1:0] rsp_count
);

  // Classifier to accumulator, hold from the controller
  bin_stream_if bin_stream ();

  // Controller to accumulator
  host_access_if host_access ();

  bin_classifier classifier (
    .port_0_clock(port_0_clock),
    .rst(rst),
    .in_valid(in_valid),
    .in_sample(in_sample),
    .in_ready(in_ready),
    .out(bin_stream.src)
  );

  bin_accumulator accumulator (
    .port_0_clock(port_0_clock),
    .rst(rst),
    .in(bin_stream.dst),
    .host(host_access.acc)
  );

  histogram_control control (
    .port_0_clock(port_0_clock),
    .rst(rst),
    .cmd_valid(cmd_valid),
    .cmd_op(cmd_op),
    .cmd_bin(cmd_bin),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_count(rsp_count),
    .stream(bin_stream.ctl),
    .host(host_access.ctl)
  );

endmodule

// ==== dv/histogram_tb.sv ====
/*
  Self-checking testbench for histogram_top, single clock, 8 ns period
  Reference model counts only in_valid/in_ready handshakes, saturating
  Reads compare against the model in the response cycle, intake is closed then
*/
`timescale 1ns/1ps

module histogram_tb;
  import hist_pkg::*;

  // Sample budget per test, drives the watchdog
  localparam int n_random = 3000;
  localparam int n_forward = 120;
  localparam int n_saturate = 65540;
  localparam int n_mixed = 2000;
  localparam int watchdog_cycles =
    (n_random + n_forward + n_saturate + n_mixed) * 10 + 50000;
  localparam int wait_limit = 4000;

  logic port_0_clock;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic [sample_width-1:0] in_sample;
  logic cmd_valid;
  logic cmd_ready;
  hist_op_e cmd_op;
  logic [bin_width-1:0] cmd_bin;
  logic rsp_valid;
  logic [count_width-1:0] rsp_count;

  // Reference counts
  logic [count_width-1:0] model [bin_count];
  logic [31:0] lcg_state;
  int error_count;
  int commands_issued;
  int rsp_pulses;
  int tests_run;
  logic reset_seen;

  histogram_top dut0 (
    .port_0_clock(port_0_clock),
    .rst(rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_sample(in_sample),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op(cmd_op),
    .cmd_bin(cmd_bin),
    .rsp_valid(rsp_valid),
    .rsp_count(rsp_count)
  );

  always #4 port_0_clock = ~port_0_clock;

  // Past the first edge the reset values are defined
  always @(posedge port_0_clock) begin
    reset_seen <= 1'b1;
  end

  // Model update on each accepted sample, counted mid-cycle before its edge
  always @(negedge port_0_clock) begin
    if (!rst && in_valid && in_ready) begin
      if (model[in_sample[sample_width-1 -: bin_width]] != count_max) begin
        model[in_sample[sample_width-1 -: bin_width]] =
          model[in_sample[sample_width-1 -: bin_width]] + 1'b1;
      end
    end
    if (!rst && rsp_valid) begin
      rsp_pulses = rsp_pulses + 1;
    end
  end

  a_reset_quiet : assert property (@(posedge port_0_clock)
    rst && reset_seen |-> !in_ready && !cmd_ready && !rsp_valid)
    else begin
      error_count = error_count + 1;
      $display("in_ready, cmd_ready or rsp_valid was high during reset");
    end

  a_rsp_one_cycle : assert property (@(posedge port_0_clock) disable iff (rst)
    rsp_valid |=> !rsp_valid)
    else begin
      error_count = error_count + 1;
      $display("rsp_valid stayed high for more than one cycle");
    end

  // Intake must close once a command is taken, and stay closed at the response
  a_intake_closed : assert property (@(posedge port_0_clock) disable iff (rst)
    (cmd_valid && cmd_ready |=> !in_ready) and (rsp_valid |-> !in_ready))
    else begin
      error_count = error_count + 1;
      $display("in_ready was high while a command was running");
    end

  // Numerical Recipes LCG, upper bits are the useful ones
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Starts and ends 1 ns after an edge
  task automatic send_sample(input logic [sample_width-1:0] sample, input int gap);
    int waited;
    logic taken;
    if (gap > 0) begin
      in_valid = 1'b0;
      repeat (gap) begin
        @(posedge port_0_clock);
        #1;
      end
    end
    in_valid = 1'b1;
    in_sample = sample;
    taken = 1'b0;
    waited = 0;
    while (!taken && waited < wait_limit) begin
      // Ready is settled here and holds until the next edge
      taken = in_ready;
      @(posedge port_0_clock);
      #1;
      waited = waited + 1;
    end
    if (!taken) begin
      error_count = error_count + 1;
      $display("Sample %03h was never accepted", sample);
    end
  endtask

  task automatic idle_cycles(input int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge port_0_clock);
      #1;
    end
  endtask

  // Issue one command and check its response against the model
  task automatic run_command(input hist_op_e op, input logic [bin_width-1:0] bin,
                             output logic [count_width-1:0] count);
    int waited;
    logic seen;
    logic [count_width-1:0] expected;
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_bin = bin;
    seen = 1'b0;
    waited = 0;
    expected = '0;
    count = '0;
    while (!seen && waited < wait_limit) begin
      seen = cmd_ready;
      @(posedge port_0_clock);
      #1;
      waited = waited + 1;
    end
    cmd_valid = 1'b0;
    if (!seen) begin
      error_count = error_count + 1;
      $display("Command was not accepted, cmd_ready stayed low");
    end else begin
      commands_issued = commands_issued + 1;
      seen = 1'b0;
      waited = 0;
      while (!seen && waited < wait_limit) begin
        if (rsp_valid) begin
          seen = 1'b1;
          count = rsp_count;
          expected = (op == op_read) ? model[bin] : '0;
          // A finished clear empties every bin
          if (op == op_clear) begin
            for (int b = 0; b < bin_count; b++) begin
              model[b] = '0;
            end
          end
        end
        @(posedge port_0_clock);
        #1;
        waited = waited + 1;
      end
      if (!seen) begin
        error_count = error_count + 1;
        $display("No response arrived for an accepted command");
      end else if (count !== expected) begin
        error_count = error_count + 1;
        $display("ERR rsp_count bin %02h expected %04h got %04h", bin, expected, count);
      end
    end
  endtask

  task automatic check_all_bins();
    logic [count_width-1:0] count;
    for (int b = 0; b < bin_count; b++) begin
      run_command(op_read, b[bin_width-1:0], count);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
  endtask

  initial begin
    logic [count_width-1:0] count;
    logic [31:0] r;
    int mark;
    port_0_clock = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_sample = '0;
    cmd_valid = 1'b0;
    cmd_op = op_clear;
    cmd_bin = '0;
    reset_seen = 1'b0;
    lcg_state = 32'h9910bb8d;
    error_count = 0;
    commands_issued = 0;
    rsp_pulses = 0;
    tests_run = 0;
    for (int b = 0; b < bin_count; b++) begin
      model[b] = '0;
    end
    repeat (2) @(posedge port_0_clock);
    #1;
    rst = 1'b0;

    // Reset values, then clear and read back zeros
    mark = error_count;
    run_command(op_clear, '0, count);
    check_all_bins();
    end_test("reset_and_clear", mark);

    // Random samples with random gaps
    mark = error_count;
    for (int i = 0; i < n_random; i++) begin
      r = next_rand();
      send_sample(r[31:20], int'(r[1:0]));
    end
    idle_cycles(2);
    check_all_bins();
    end_test("random_stream", mark);

    // Back-to-back same bin, then same bin two apart
    mark = error_count;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      send_sample({6'd9, r[25:20]}, 0);
    end
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      send_sample({(i % 2 == 0) ? 6'd20 : 6'd21, r[25:20]}, 0);
    end
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      send_sample({5'd15, r[31], r[25:20]}, 0);
    end
    idle_cycles(2);
    check_all_bins();
    end_test("forwarding", mark);

    // Saturation of one counter
    mark = error_count;
    run_command(op_clear, '0, count);
    for (int i = 0; i < n_saturate; i++) begin
      r = next_rand();
      send_sample({6'd63, r[25:20]}, 0);
    end
    idle_cycles(2);
    run_command(op_read, 6'd63, count);
    if (count !== count_max) begin
      error_count = error_count + 1;
      $display("ERR rsp_count bin 3f expected %04h got %04h", count_max, count);
    end
    end_test("saturation", mark);

    // Commands while samples keep streaming
    mark = error_count;
    fork
      begin
        for (int i = 0; i < n_mixed; i++) begin
          r = next_rand();
          send_sample(r[31:20], (r[2:0] == 3'd0) ? 1 : 0);
        end
        idle_cycles(1);
      end
      begin
        logic [31:0] cr;
        logic [count_width-1:0] ccount;
        for (int k = 0; k < 12; k++) begin
          cr = next_rand();
          repeat (20 + int'(cr[6:0])) begin
            @(posedge port_0_clock);
            #1;
          end
          // One clear in the middle of the stream
          if (k == 6) begin
            run_command(op_clear, '0, ccount);
          end else begin
            run_command(op_read, cr[31:26], ccount);
          end
        end
      end
    join
    idle_cycles(2);
    check_all_bins();
    if (rsp_pulses != commands_issued) begin
      error_count = error_count + 1;
      $display("ERR rsp_valid pulses expected %08h got %08h", commands_issued, rsp_pulses);
    end
    end_test("commands_during_stream", mark);

    $display("tests %0d, commands %0d, errors %0d", tests_run, commands_issued, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Run limit from the sample budget
  initial begin
    repeat (watchdog_cycles) @(posedge port_0_clock);
    $display("Watchdog expired before the tests finished");
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== all.f ====
src/hist_pkg.sv
src/hist_if.sv
src/true_dual_port_ram.sv
src/bin_classifier.sv
src/bin_accumulator.sv
src/histogram_control.sv
src/histogram_top.sv
dv/histogram_tb.sv
